/* rtl/pagerank_pkg.sv */
// Widths, vector types, array tags and buffer depths of the PageRank vertex unit
package pagerank_pkg;

	// Field widths
	localparam int VERTEX_BITS = 16;
	localparam int EDGE_BITS   = 20;
	localparam int DEGREE_BITS = 8;

	typedef logic [VERTEX_BITS-1:0] vertex_t;
	typedef logic [EDGE_BITS-1:0]   edge_index_t;
	typedef logic [DEGREE_BITS-1:0] degree_t;

	// Byte address on the read bus
	typedef logic [31:0] addr_t;

	// Rank contribution or running sum
	typedef logic [31:0] rank_t;

	// Array a read command targets; read data returns with the same tag
	typedef enum logic [1:0] {
		TAG_NONE       = 2'd0,
		TAG_EDGE_ARRAY = 2'd1,
		TAG_GRAPH_DATA = 2'd2
	} array_tag_e;

	// One element is one 32-bit word
	localparam int WORD_BYTES = 4;

	////////////////////////////////////////////////////////////////////////////
	// Buffer depths and limits
	////////////////////////////////////////////////////////////////////////////

	// Destination ids waiting for their graph data read
	localparam int EDGE_QUEUE_DEPTH = 8;

	// Finished vertices waiting for the write bus
	localparam int WRITE_QUEUE_DEPTH = 4;

	// Graph data reads in flight, pending request included
	localparam int MAX_OUTSTANDING = 4;

endpackage

/* rtl/vertex_sync_fifo.sv */
// Synchronous circular-buffer FIFO with show-ahead output and almost-full level
`timescale 1ns/1ps

module vertex_sync_fifo #(
	parameter int WIDTH    = 32,
	parameter int DEPTH    = 8,
	parameter int HEADROOM = 1
) (
	input  logic             clock,
	input  logic             rstn,
	input  logic             push,
	input  logic [WIDTH-1:0] data_in,
	input  logic             pop,
	output logic [WIDTH-1:0] data_out,
	output logic             empty,
	output logic             full,
	output logic             alfull
);

	localparam int PTR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_BITS = $clog2(DEPTH + 1);

	logic [WIDTH-1:0]    mem [DEPTH];
	logic [PTR_BITS-1:0] wr_ptr;
	logic [PTR_BITS-1:0] rd_ptr;
	logic [CNT_BITS-1:0] count;
	logic                do_push;
	logic                do_pop;

	function automatic logic [PTR_BITS-1:0] next_ptr(input logic [PTR_BITS-1:0] ptr);
		return (ptr == PTR_BITS'(DEPTH - 1)) ? '0 : ptr + 1'b1;
	endfunction

	// Overflow and underflow are dropped
	assign do_push = push && !full;
	assign do_pop  = pop && !empty;

	assign empty    = (count == '0);
	assign full     = (count == CNT_BITS'(DEPTH));
	assign alfull   = (count >= CNT_BITS'(DEPTH - HEADROOM));
	assign data_out = mem[rd_ptr];

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push)
				wr_ptr <= next_ptr(wr_ptr);
			if (do_pop)
				rd_ptr <= next_ptr(rd_ptr);
			count <= count + CNT_BITS'(do_push) - CNT_BITS'(do_pop);
		end
	end

	always_ff @(posedge clock) begin
		if (do_push)
			mem[wr_ptr] <= data_in;
	end

endmodule

/* rtl/read_command_arbiter.sv */
// Round-robin arbiter of the two fetchers onto the registered read command bus
`timescale 1ns/1ps

module read_command_arbiter (
	input  logic                   clock,
	input  logic                   rstn,
	input  logic [1:0]             req,
	input  pagerank_pkg::addr_t    req_addr_0,
	input  pagerank_pkg::addr_t    req_addr_1,
	output logic [1:0]             grant,
	input  logic                   read_bus_alfull,
	output logic                   read_cmd_valid,
	output pagerank_pkg::array_tag_e read_cmd_tag,
	output pagerank_pkg::addr_t    read_cmd_addr
);

	import pagerank_pkg::*;

	// Index of the requester that wins a tie
	logic prio;

	always_comb begin
		grant = 2'b00;
		if (!read_bus_alfull) begin
			if (req[prio])
				grant[prio] = 1'b1;
			else if (req[~prio])
				grant[~prio] = 1'b1;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Command register
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			prio           <= 1'b0;
			read_cmd_valid <= 1'b0;
		end else begin
			read_cmd_valid <= |grant;
			// Last winner drops to low priority
			if (grant[0])
				prio <= 1'b1;
			else if (grant[1])
				prio <= 1'b0;
		end
	end

	// Requester 0 reads the edge array, requester 1 the graph data
	always_ff @(posedge clock) begin
		if (|grant) begin
			read_cmd_addr <= grant[0] ? req_addr_0 : req_addr_1;
			read_cmd_tag  <= grant[0] ? TAG_EDGE_ARRAY : TAG_GRAPH_DATA;
		end
	end

endmodule

/* rtl/edge_job_fetch.sv */
// Edge array read FSM with queue credits, and the queue of returned edge jobs
`timescale 1ns/1ps

module edge_job_fetch #(
	parameter pagerank_pkg::addr_t EDGE_ARRAY_BASE = 32'h0001_0000
) (
	input  logic                      clock,
	input  logic                      rstn,
	input  logic                      job_start,
	input  pagerank_pkg::edge_index_t job_edge_start,
	input  pagerank_pkg::degree_t     job_degree,
	output logic                      req,
	output pagerank_pkg::addr_t       req_addr,
	input  logic                      grant,
	input  logic                      edge_data_valid,
	input  pagerank_pkg::vertex_t     edge_data_id,
	input  logic                      queue_pop,
	output pagerank_pkg::vertex_t     queue_head,
	output logic                      queue_empty
);

	import pagerank_pkg::*;

	localparam int CREDIT_BITS = $clog2(EDGE_QUEUE_DEPTH + 1);

	typedef enum logic [1:0] {
		FETCH_IDLE,
		FETCH_ISSUE,
		FETCH_DONE
	} fetch_state_e;

	fetch_state_e           state;
	edge_index_t            edge_idx;
	degree_t                remaining;
	// Reads in flight plus entries held in the queue
	logic [CREDIT_BITS-1:0] used;
	logic                   slot_free;
	logic                   issue;

	assign slot_free = !req || grant;
	assign issue     = (state == FETCH_ISSUE) && slot_free && (remaining != '0) &&
	                   (used < CREDIT_BITS'(EDGE_QUEUE_DEPTH));

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			state     <= FETCH_IDLE;
			req       <= 1'b0;
			edge_idx  <= '0;
			remaining <= '0;
		end else begin
			case (state)
				FETCH_IDLE: begin
					if (job_start) begin
						edge_idx  <= job_edge_start;
						remaining <= job_degree;
						state     <= FETCH_ISSUE;
					end
				end
				FETCH_ISSUE: begin
					if (issue) begin
						req       <= 1'b1;
						edge_idx  <= edge_idx + 1'b1;
						remaining <= remaining - 1'b1;
					end else if (grant) begin
						req <= 1'b0;
					end
					// Leave once the last read has been granted
					if (remaining == '0 && slot_free)
						state <= FETCH_DONE;
				end
				FETCH_DONE:
					state <= FETCH_IDLE;
				default:
					state <= FETCH_IDLE;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (issue)
			req_addr <= EDGE_ARRAY_BASE + addr_t'(edge_idx) * addr_t'(WORD_BYTES);
	end

	// A credit is taken when a read is raised and returned when its id is popped
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn)
			used <= '0;
		else
			used <= used + CREDIT_BITS'(issue) - CREDIT_BITS'(queue_pop);
	end

	vertex_sync_fifo #(
		.WIDTH   (VERTEX_BITS),
		.DEPTH   (EDGE_QUEUE_DEPTH),
		.HEADROOM(1)
	) i_edge_queue (
		.clock   (clock),
		.rstn    (rstn),
		.push    (edge_data_valid),
		.data_in (edge_data_id),
		.pop     (queue_pop),
		.data_out(queue_head),
		.empty   (queue_empty),
		.full    (),
		.alfull  ()
	);

endmodule

/* rtl/edge_data_fetch.sv */
// Graph data reads for queued edge jobs, with a limit on reads in flight
`timescale 1ns/1ps

module edge_data_fetch #(
	parameter pagerank_pkg::addr_t GRAPH_DATA_BASE = 32'h0010_0000
) (
	input  logic                  clock,
	input  logic                  rstn,
	input  pagerank_pkg::vertex_t queue_head,
	input  logic                  queue_empty,
	output logic                  queue_pop,
	output logic                  req,
	output pagerank_pkg::addr_t   req_addr,
	input  logic                  grant,
	input  logic                  graph_data_valid,
	input  pagerank_pkg::rank_t   graph_data_value,
	output logic                  contrib_valid,
	output pagerank_pkg::rank_t   contrib_value
);

	import pagerank_pkg::*;

	localparam int OUT_BITS = $clog2(MAX_OUTSTANDING + 1);

	// Pending request plus reads still waiting for data
	logic [OUT_BITS-1:0] reserved;

	// Take the next edge job when the request slot frees up
	assign queue_pop = !queue_empty && (!req || grant) &&
	                   (reserved < OUT_BITS'(MAX_OUTSTANDING));

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			req      <= 1'b0;
			reserved <= '0;
		end else begin
			if (queue_pop)
				req <= 1'b1;
			else if (grant)
				req <= 1'b0;
			reserved <= reserved + OUT_BITS'(queue_pop) - OUT_BITS'(graph_data_valid);
		end
	end

	always_ff @(posedge clock) begin
		if (queue_pop)
			req_addr <= GRAPH_DATA_BASE + addr_t'(queue_head) * addr_t'(WORD_BYTES);
	end

	////////////////////////////////////////////////////////////////////////////
	// Contribution forwarding
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn)
			contrib_valid <= 1'b0;
		else
			contrib_valid <= graph_data_valid;
	end

	always_ff @(posedge clock) begin
		if (graph_data_valid)
			contrib_value <= graph_data_value;
	end

endmodule

/* rtl/rank_sum_kernel.sv */
// Per-vertex rank accumulation, completion, counters and the output write queue
`timescale 1ns/1ps

module rank_sum_kernel (
	input  logic                      clock,
	input  logic                      rstn,
	input  logic                      job_start,
	input  pagerank_pkg::vertex_t     job_vertex,
	input  pagerank_pkg::degree_t     job_degree,
	input  logic                      contrib_valid,
	input  pagerank_pkg::rank_t       contrib_value,
	output logic                      busy,
	output logic                      write_queue_alfull,
	input  logic                      write_bus_alfull,
	output logic                      write_valid,
	output pagerank_pkg::vertex_t     write_vertex,
	output pagerank_pkg::rank_t       write_sum,
	output pagerank_pkg::vertex_t     vertex_num_counter,
	output pagerank_pkg::edge_index_t edge_num_counter
);

	import pagerank_pkg::*;

	localparam int WRITE_BITS = VERTEX_BITS + 32;

	degree_t               edge_count;
	rank_t                 sum;
	rank_t                 sum_next;
	logic                  last_contrib;
	logic                  write_pop;
	logic                  write_empty;
	logic [WRITE_BITS-1:0] write_head;

	// Wraps modulo 2^32
	assign sum_next     = sum + contrib_value;
	assign last_contrib = contrib_valid && (degree_t'(edge_count + 1'b1) == job_degree);

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			busy               <= 1'b0;
			edge_count         <= '0;
			sum                <= '0;
			vertex_num_counter <= '0;
			edge_num_counter   <= '0;
		end else begin
			if (job_start)
				busy <= 1'b1;
			else if (last_contrib)
				busy <= 1'b0;
			// Clear for the next vertex once the sum is pushed
			if (last_contrib) begin
				edge_count         <= '0;
				sum                <= '0;
				vertex_num_counter <= vertex_num_counter + 1'b1;
			end else if (contrib_valid) begin
				edge_count <= edge_count + 1'b1;
				sum        <= sum_next;
			end
			if (contrib_valid)
				edge_num_counter <= edge_num_counter + 1'b1;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Output write queue
	////////////////////////////////////////////////////////////////////////////

	assign write_pop = !write_empty && !write_bus_alfull;

	vertex_sync_fifo #(
		.WIDTH   (WRITE_BITS),
		.DEPTH   (WRITE_QUEUE_DEPTH),
		.HEADROOM(1)
	) i_write_queue (
		.clock   (clock),
		.rstn    (rstn),
		.push    (last_contrib),
		.data_in ({job_vertex, sum_next}),
		.pop     (write_pop),
		.data_out(write_head),
		.empty   (write_empty),
		.full    (),
		.alfull  (write_queue_alfull)
	);

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn)
			write_valid <= 1'b0;
		else
			write_valid <= write_pop;
	end

	always_ff @(posedge clock) begin
		if (write_pop) begin
			write_vertex <= write_head[WRITE_BITS-1:32];
			write_sum    <= write_head[31:0];
		end
	end

endmodule

/* rtl/cu_vertex_pagerank.sv */
// PageRank vertex compute unit top with job latch and tag-routed read data
`timescale 1ns/1ps

module cu_vertex_pagerank #(
	parameter pagerank_pkg::addr_t EDGE_ARRAY_BASE = 32'h0001_0000,
	parameter pagerank_pkg::addr_t GRAPH_DATA_BASE = 32'h0010_0000
) (
	input  logic                      clock,
	input  logic                      rstn,
	input  logic                      vertex_job_valid,
	input  pagerank_pkg::vertex_t     vertex_job_id,
	input  pagerank_pkg::edge_index_t vertex_job_edge_start,
	input  pagerank_pkg::degree_t     vertex_job_degree,
	output logic                      vertex_job_request,
	output logic                      read_cmd_valid,
	output pagerank_pkg::array_tag_e  read_cmd_tag,
	output pagerank_pkg::addr_t       read_cmd_addr,
	input  logic                      read_bus_alfull,
	input  logic                      read_data_valid,
	input  pagerank_pkg::array_tag_e  read_data_tag,
	input  pagerank_pkg::rank_t       read_data_value,
	output logic                      write_valid,
	output pagerank_pkg::vertex_t     write_vertex,
	output pagerank_pkg::rank_t       write_sum,
	input  logic                      write_bus_alfull,
	output pagerank_pkg::vertex_t     vertex_num_counter,
	output pagerank_pkg::edge_index_t edge_num_counter
);

	import pagerank_pkg::*;

	logic        job_accept;
	logic        job_start;
	vertex_t     job_id;
	edge_index_t job_edge_start;
	degree_t     job_degree;
	logic        busy;
	logic        write_queue_alfull;

	logic        edge_data_valid;
	logic        graph_data_valid;
	rank_t       read_value_q;

	logic [1:0]  req;
	logic [1:0]  grant;
	addr_t       job_fetch_addr;
	addr_t       data_fetch_addr;
	vertex_t     queue_head;
	logic        queue_empty;
	logic        queue_pop;
	logic        contrib_valid;
	rank_t       contrib_value;

	////////////////////////////////////////////////////////////////////////////
	// Vertex job latch
	////////////////////////////////////////////////////////////////////////////

	assign job_accept = vertex_job_valid && vertex_job_request;

	// Request stays low through the accept, the start and the busy vertex
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			vertex_job_request <= 1'b0;
			job_start          <= 1'b0;
		end else begin
			vertex_job_request <= !job_accept && !job_start && !busy && !write_queue_alfull;
			job_start          <= job_accept;
		end
	end

	always_ff @(posedge clock) begin
		if (job_accept) begin
			job_id         <= vertex_job_id;
			job_edge_start <= vertex_job_edge_start;
			job_degree     <= vertex_job_degree;
		end
	end

	// Read data router
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			edge_data_valid  <= 1'b0;
			graph_data_valid <= 1'b0;
		end else begin
			edge_data_valid  <= read_data_valid && (read_data_tag == TAG_EDGE_ARRAY);
			graph_data_valid <= read_data_valid && (read_data_tag == TAG_GRAPH_DATA);
		end
	end

	always_ff @(posedge clock) begin
		if (read_data_valid)
			read_value_q <= read_data_value;
	end

	////////////////////////////////////////////////////////////////////////////
	// Datapath
	////////////////////////////////////////////////////////////////////////////

	read_command_arbiter i_arbiter (
		.clock          (clock),
		.rstn           (rstn),
		.req            (req),
		.req_addr_0     (job_fetch_addr),
		.req_addr_1     (data_fetch_addr),
		.grant          (grant),
		.read_bus_alfull(read_bus_alfull),
		.read_cmd_valid (read_cmd_valid),
		.read_cmd_tag   (read_cmd_tag),
		.read_cmd_addr  (read_cmd_addr)
	);

	edge_job_fetch #(
		.EDGE_ARRAY_BASE(EDGE_ARRAY_BASE)
	) i_edge_job_fetch (
		.clock          (clock),
		.rstn           (rstn),
		.job_start      (job_start),
		.job_edge_start (job_edge_start),
		.job_degree     (job_degree),
		.req            (req[0]),
		.req_addr       (job_fetch_addr),
		.grant          (grant[0]),
		.edge_data_valid(edge_data_valid),
		.edge_data_id   (read_value_q[VERTEX_BITS-1:0]),
		.queue_pop      (queue_pop),
		.queue_head     (queue_head),
		.queue_empty    (queue_empty)
	);

	edge_data_fetch #(
		.GRAPH_DATA_BASE(GRAPH_DATA_BASE)
	) i_edge_data_fetch (
		.clock           (clock),
		.rstn            (rstn),
		.queue_head      (queue_head),
		.queue_empty     (queue_empty),
		.queue_pop       (queue_pop),
		.req             (req[1]),
		.req_addr        (data_fetch_addr),
		.grant           (grant[1]),
		.graph_data_valid(graph_data_valid),
		.graph_data_value(read_value_q),
		.contrib_valid   (contrib_valid),
		.contrib_value   (contrib_value)
	);

	rank_sum_kernel i_rank_sum_kernel (
		.clock             (clock),
		.rstn              (rstn),
		.job_start         (job_start),
		.job_vertex        (job_id),
		.job_degree        (job_degree),
		.contrib_valid     (contrib_valid),
		.contrib_value     (contrib_value),
		.busy              (busy),
		.write_queue_alfull(write_queue_alfull),
		.write_bus_alfull  (write_bus_alfull),
		.write_valid       (write_valid),
		.write_vertex      (write_vertex),
		.write_sum         (write_sum),
		.vertex_num_counter(vertex_num_counter),
		.edge_num_counter  (edge_num_counter)
	);

endmodule

/* tests/cu_vertex_pagerank_checker.sv */
// Bound assertions on the read command bus and the reset state of the vertex unit
`timescale 1ns/1ps

module cu_vertex_pagerank_checker (
	input logic                     clock,
	input logic                     rstn,
	input logic                     vertex_job_request,
	input logic                     read_cmd_valid,
	input pagerank_pkg::array_tag_e read_cmd_tag,
	input logic                     read_bus_alfull,
	input logic                     write_valid
);

	import pagerank_pkg::*;

	// Grant cycle sits one cycle before the command
	cmd_after_free_bus: assert property (@(posedge clock) disable iff (!rstn)
		read_cmd_valid |-> $past(!read_bus_alfull))
		else $error("read command issued after a cycle with the read bus almost full");

	cmd_tag_known: assert property (@(posedge clock) disable iff (!rstn)
		read_cmd_valid |-> (read_cmd_tag != TAG_NONE))
		else $error("read command carries no array tag");

	quiet_in_reset: assert property (@(posedge clock)
		!rstn |-> (!vertex_job_request && !read_cmd_valid && !write_valid))
		else $error("control output active during reset");

endmodule

/* tests/cu_vertex_pagerank_tb.sv */
// Testbench of the PageRank vertex unit with memory model, reference sums and watchdog
`timescale 1ns/1ps

module cu_vertex_pagerank_tb;

	import pagerank_pkg::*;

	localparam addr_t EDGE_ARRAY_BASE = 32'h0002_0000;
	localparam addr_t GRAPH_DATA_BASE = 32'h0040_0000;
	localparam int NUM_JOBS       = 40;
	localparam int MAX_DEGREE     = 12;
	localparam int EDGE_ADDR_BITS = 10;
	localparam int DEST_BITS      = 8;
	localparam int EDGE_WORDS     = 1 << EDGE_ADDR_BITS;
	localparam int VERTEX_WORDS   = 1 << DEST_BITS;
	localparam int RESET_CYCLES   = 16;
	// Generous cycles per edge slot under random back-pressure
	localparam int CYCLE_BOUND    = 40;
	localparam int TIMEOUT_NS     =
		(NUM_JOBS * MAX_DEGREE * CYCLE_BOUND + RESET_CYCLES + 100) * 10;

	logic        clock;
	logic        rstn;
	logic        vertex_job_valid;
	vertex_t     vertex_job_id;
	edge_index_t vertex_job_edge_start;
	degree_t     vertex_job_degree;
	logic        vertex_job_request;
	logic        read_cmd_valid;
	array_tag_e  read_cmd_tag;
	addr_t       read_cmd_addr;
	logic        read_bus_alfull;
	logic        read_data_valid;
	array_tag_e  read_data_tag;
	rank_t       read_data_value;
	logic        write_valid;
	vertex_t     write_vertex;
	rank_t       write_sum;
	logic        write_bus_alfull;
	vertex_t     vertex_num_counter;
	edge_index_t edge_num_counter;

	// Memory model and reference state
	vertex_t     edge_mem [EDGE_WORDS];
	rank_t       graph_mem [VERTEX_WORDS];
	logic [31:0] rng;
	edge_index_t edge_read_q [$];
	vertex_t     graph_read_q [$];
	vertex_t     edge_answer_q [$];
	rank_t       graph_answer_q [$];
	vertex_t     expect_vertex_q [$];
	rank_t       expect_sum_q [$];
	int          jobs_sent;
	int          writes_seen;
	int          total_degree;
	int          cycles_run;

	always #5 clock = ~clock;

	cu_vertex_pagerank #(
		.EDGE_ARRAY_BASE(EDGE_ARRAY_BASE),
		.GRAPH_DATA_BASE(GRAPH_DATA_BASE)
	) i_dut (.*);

	bind cu_vertex_pagerank cu_vertex_pagerank_checker i_checker (
		.clock             (clock),
		.rstn              (rstn),
		.vertex_job_request(vertex_job_request),
		.read_cmd_valid    (read_cmd_valid),
		.read_cmd_tag      (read_cmd_tag),
		.read_bus_alfull   (read_bus_alfull),
		.write_valid       (write_valid)
	);

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("TEST FAIL");
		$fatal(1, "stopping at the first failure");
	endtask

	task automatic check_equal(input string name, input logic [31:0] expected,
	                           input logic [31:0] actual);
		if (expected !== actual)
			abort_run($sformatf("error %s expected 0x%0h actual 0x%0h", name, expected, actual));
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Bus observers
	////////////////////////////////////////////////////////////////////////////

	// Read commands checked in order and answered from the memory model
	task automatic observe_read_cmd();
		edge_index_t idx;
		vertex_t     dest;
		if (read_cmd_valid && read_cmd_tag == TAG_EDGE_ARRAY) begin
			if (edge_read_q.size() == 0) begin
				abort_run("edge array read issued beyond the degree of the job");
			end else begin
				idx = edge_read_q.pop_front();
				check_equal("edge read address",
				            EDGE_ARRAY_BASE + addr_t'(idx) * addr_t'(WORD_BYTES), read_cmd_addr);
				edge_answer_q.push_back(edge_mem[idx[EDGE_ADDR_BITS-1:0]]);
			end
		end else if (read_cmd_valid && read_cmd_tag == TAG_GRAPH_DATA) begin
			if (graph_read_q.size() == 0) begin
				abort_run("graph data read issued with no returned destination id");
			end else begin
				dest = graph_read_q.pop_front();
				check_equal("graph data read address",
				            GRAPH_DATA_BASE + addr_t'(dest) * addr_t'(WORD_BYTES), read_cmd_addr);
				graph_answer_q.push_back(graph_mem[dest[DEST_BITS-1:0]]);
			end
		end else if (read_cmd_valid) begin
			abort_run("read command issued with an unknown array tag");
		end
	endtask

	// The write bus level seen here is the one of the cycle that popped the write
	task automatic observe_write();
		vertex_t exp_vertex;
		rank_t   exp_sum;
		if (write_valid) begin
			if (write_bus_alfull) begin
				abort_run("vertex write left the queue while the write bus was almost full");
			end else if (expect_vertex_q.size() == 0) begin
				abort_run("vertex write seen with no accepted job waiting for it");
			end else begin
				exp_vertex = expect_vertex_q.pop_front();
				exp_sum    = expect_sum_q.pop_front();
				check_equal("write vertex", 32'(exp_vertex), 32'(write_vertex));
				check_equal("write sum", exp_sum, write_sum);
				writes_seen++;
			end
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////////////////////////////////////////

	task automatic drive_job();
		degree_t     degree;
		edge_index_t start;
		edge_index_t e;
		vertex_t     id;
		rank_t       sum;
		rng = xorshift(rng);
		vertex_job_valid      = 1'b0;
		vertex_job_id         = rng[31:16];
		vertex_job_edge_start = rng[19:0];
		vertex_job_degree     = rng[7:0];
		if (jobs_sent < NUM_JOBS && vertex_job_request && rng[9:8] != 2'b00) begin
			degree = degree_t'(1 + int'(rng[15:10]) % MAX_DEGREE);
			rng    = xorshift(rng);
			start  = edge_index_t'(int'(rng[19:0]) % (EDGE_WORDS - MAX_DEGREE));
			id     = rng[31:16];
			// Reference sum over the destinations of this vertex modulo 2^32
			sum = '0;
			for (int k = 0; k < int'(degree); k++) begin
				e = start + edge_index_t'(k);
				edge_read_q.push_back(e);
				sum = sum + graph_mem[edge_mem[e[EDGE_ADDR_BITS-1:0]][DEST_BITS-1:0]];
			end
			expect_vertex_q.push_back(id);
			expect_sum_q.push_back(sum);
			total_degree += int'(degree);
			jobs_sent++;
			vertex_job_valid      = 1'b1;
			vertex_job_id         = id;
			vertex_job_edge_start = start;
			vertex_job_degree     = degree;
		end else if (!vertex_job_request) begin
			// Offers while the request is low must be ignored
			vertex_job_valid = rng[10];
		end
	endtask

	// At most one answer per cycle and in order within each tag
	task automatic drive_answer();
		logic    pick_graph;
		vertex_t dest;
		rng = xorshift(rng);
		read_data_valid = 1'b0;
		read_data_tag   = TAG_NONE;
		read_data_value = rng;
		if (rng[20] && (edge_answer_q.size() != 0 || graph_answer_q.size() != 0)) begin
			pick_graph = (edge_answer_q.size() == 0) || (graph_answer_q.size() != 0 && rng[21]);
			read_data_valid = 1'b1;
			if (pick_graph) begin
				read_data_tag   = TAG_GRAPH_DATA;
				read_data_value = graph_answer_q.pop_front();
			end else begin
				dest            = edge_answer_q.pop_front();
				read_data_tag   = TAG_EDGE_ARRAY;
				read_data_value = rank_t'(dest);
				graph_read_q.push_back(dest);
			end
		end
	endtask

	task automatic service_cycle();
		observe_read_cmd();
		observe_write();
		drive_job();
		drive_answer();
		rng = xorshift(rng);
		cycles_run++;
		read_bus_alfull  = (rng[2:0] < 3'd2);
		// Long write bus stalls let the write queue fill up
		write_bus_alfull = cycles_run[7] || (rng[5:3] < 3'd3);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Main sequence and watchdog
	////////////////////////////////////////////////////////////////////////////

	initial begin
		clock                 = 1'b0;
		rstn                  = 1'b0;
		vertex_job_valid      = 1'b0;
		vertex_job_id         = '0;
		vertex_job_edge_start = '0;
		vertex_job_degree     = '0;
		read_bus_alfull       = 1'b0;
		read_data_valid       = 1'b0;
		read_data_tag         = TAG_NONE;
		read_data_value       = '0;
		write_bus_alfull      = 1'b0;
		rng          = 32'hb9e6_f878;
		jobs_sent    = 0;
		writes_seen  = 0;
		total_degree = 0;
		cycles_run   = 0;
		for (int i = 0; i < EDGE_WORDS; i++) begin
			rng = xorshift(rng);
			edge_mem[i[EDGE_ADDR_BITS-1:0]] = vertex_t'(rng[DEST_BITS-1:0]);
		end
		for (int i = 0; i < VERTEX_WORDS; i++) begin
			rng = xorshift(rng);
			graph_mem[i[DEST_BITS-1:0]] = rng;
		end
		repeat (RESET_CYCLES) @(negedge clock);
		rstn = 1'b1;
		@(negedge clock);
		check_equal("job request after reset", 32'd1, 32'(vertex_job_request));
		check_equal("read command after reset", 32'd0, 32'(read_cmd_valid));
		check_equal("write after reset", 32'd0, 32'(write_valid));
		check_equal("vertex count after reset", 32'd0, 32'(vertex_num_counter));
		check_equal("edge count after reset", 32'd0, 32'(edge_num_counter));
		while (writes_seen < NUM_JOBS) begin
			service_cycle();
			@(negedge clock);
		end
		// Quiet window to catch late or duplicated traffic
		repeat (20) begin
			service_cycle();
			@(negedge clock);
		end
		check_equal("vertex count", NUM_JOBS, 32'(vertex_num_counter));
		check_equal("edge count", total_degree, 32'(edge_num_counter));
		check_equal("edge reads left", 0, edge_read_q.size());
		check_equal("graph reads left", 0, graph_read_q.size());
		check_equal("answers left", 0, edge_answer_q.size() + graph_answer_q.size());
		$display("TEST PASS");
		$finish;
	end

	initial begin
		#(TIMEOUT_NS);
		abort_run("watchdog expired before all vertex writes arrived");
	end

endmodule

/* pagerank_cu.f */
rtl/pagerank_pkg.sv
rtl/vertex_sync_fifo.sv
rtl/read_command_arbiter.sv
rtl/edge_job_fetch.sv
rtl/edge_data_fetch.sv
rtl/rank_sum_kernel.sv
rtl/cu_vertex_pagerank.sv
tests/cu_vertex_pagerank_checker.sv
tests/cu_vertex_pagerank_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the vertex unit testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -j 0 \
	--top-module cu_vertex_pagerank_tb \
	-f pagerank_cu.f \
	--Mdir build \
	-o cu_vertex_pagerank_sim
./build/cu_vertex_pagerank_sim
